// File: all.f
common/branchPkg.sv
branchPredictor/predictorControl.sv
branchPredictor/branchTargetBuffer.sv
branchPredictor/tagePredictor.sv
branchPredictor/returnStack.sv
source/backupFile.sv
source/fetchPredictTop.sv
sim/predictor_checker.sv
sim/predictorMonitor.sv
sim/predictorTb.sv

// File: branchPredictor/branchTargetBuffer.sv
`timescale 1ns/10ps

module branchTargetBuffer #(
    parameter BTB_ENTRIES = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic pcValid,
    input  branchPkg::FetchAddr_t pc,
    input  branchPkg::BTUpdate btUpdate,
    output branchPkg::PredBranch br
);
    import branchPkg::*;

    localparam int idxBits = $clog2(BTB_ENTRIES);
    localparam int tagBits = $bits(FetchAddr_t) - 3 - idxBits;

    logic [BTB_ENTRIES-1:0] entryValid;
    logic [tagBits-1:0] tags[BTB_ENTRIES];
    PredBranch entries[BTB_ENTRIES];

    logic [idxBits-1:0] readIdx;
    logic [tagBits-1:0] readTag;
    logic [idxBits-1:0] writeIdx;
    logic [tagBits-1:0] writeTag;

    // index from the low block bits, tag from the rest.
    assign readIdx = pc[3 +: idxBits];
    assign readTag = pc[$bits(FetchAddr_t)-1 -: tagBits];
    assign writeIdx = btUpdate.pc[3 +: idxBits];
    assign writeTag = btUpdate.pc[$bits(FetchAddr_t)-1 -: tagBits];

    always_comb begin
        br = entries[readIdx];
        // a branch before the fetch offset has already been passed.
        br.valid = pcValid && entryValid[readIdx] && tags[readIdx] == readTag
            && entries[readIdx].offs >= pc[2:0];
    end

    always_ff @(posedge clk) begin
        if (rst)
            entryValid <= '0;
        else if (btUpdate.valid)
            entryValid[writeIdx] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (btUpdate.valid) begin
            tags[writeIdx] <= writeTag;
            entries[writeIdx] <= '{valid: 1'b1, offs: btUpdate.offs,
                                   dst: btUpdate.dst, kind: btUpdate.kind};
        end
    end

endmodule

// File: branchPredictor/predictorControl.sv
`timescale 1ns/10ps

module predictorControl #(
    parameter NUM_IN = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic pcValid,
    input  branchPkg::FetchAddr_t pc,
    input  branchPkg::FetchID_t fetchID,
    input  branchPkg::PredBranch btbBr,
    input  logic tageTaken,
    input  branchPkg::TageID_t tageID,
    input  logic altPred,
    input  branchPkg::PredBranch retBr,
    input  branchPkg::RetStackIdx_t curIdx,
    input  branchPkg::BPBackup recBackup,
    input  branchPkg::BPBackup updBackup,
    input  logic mispr,
    input  branchPkg::FetchID_t misprFetchID,
    input  branchPkg::FetchOff_t misprOffs,
    input  branchPkg::HistoryAction misprHistAct,
    input  branchPkg::BTUpdate btUpdates[NUM_IN],
    input  branchPkg::BPUpdate bpUpdate,
    output branchPkg::PredBranch predBr,
    output logic branchTaken,
    output branchPkg::BranchPredInfo branchInfo,
    output logic stall,
    output branchPkg::BHist_t history,
    output logic writeEnable,
    output branchPkg::FetchID_t writeID,
    output branchPkg::BPBackup writeData,
    output branchPkg::FetchID_t recAddr,
    output branchPkg::FetchID_t updAddr,
    output branchPkg::BPUpdate tageWrite,
    output branchPkg::BHist_t tageWriteHistory,
    output logic setIdx,
    output branchPkg::RetStackIdx_t idx,
    output branchPkg::BTUpdate btUpdate
);
    import branchPkg::*;

    localparam int histBits = $bits(BHist_t);

    Recovery recovery;
    BHist_t recHistory;
    BPUpdate train;
    logic btbOk;
    logic retOk;

    // a candidate only counts at or after the slot being fetched.
    assign btbOk = btbBr.valid && btbBr.offs >= pc[2:0];
    assign retOk = retBr.valid && retBr.offs >= pc[2:0];

    always_comb begin
        if (retOk && (!btbOk || retBr.offs <= btbBr.offs)) begin // ties go to the return stack.
            predBr = retBr;
            branchTaken = 1'b1;
        end else begin
            predBr = btbBr;
            predBr.valid = btbOk;
            branchTaken = btbOk && (btbBr.kind != BR_COND || tageTaken);
        end
    end

    always_comb begin
        branchInfo.predicted = predBr.valid;
        branchInfo.taken = branchTaken;
        branchInfo.kind = predBr.kind;
        branchInfo.tageID = tageID;
        branchInfo.altPred = altPred;
        branchInfo.rIdx = curIdx;
    end

    assign writeEnable = pcValid;
    assign writeID = fetchID;
    assign writeData = '{history: history, rIdx: curIdx, pred: predBr.valid,
                         predTaken: branchTaken, predOffs: predBr.offs};

    // the highest valid port wins.
    always_comb begin
        btUpdate = '0;
        for (int i = 0; i < NUM_IN; i++) begin
            if (btUpdates[i].valid)
                btUpdate = btUpdates[i];
        end
    end

    assign recAddr = recovery.fetchID;
    assign updAddr = bpUpdate.fetchID;
    assign stall = recovery.valid;
    assign setIdx = recovery.valid;
    assign idx = recBackup.rIdx;

    // Replay the outcome of the mispredicted fetch onto the history it started with.
    always_comb begin
        recHistory = recBackup.history;
        if (recovery.histAct == HIST_WRITE_0 || recovery.histAct == HIST_WRITE_1)
            recHistory = {recHistory[histBits-2:0], recovery.histAct == HIST_WRITE_1};
        else if (recBackup.pred && recBackup.predOffs <= recovery.fetchOffs)
            recHistory = {recHistory[histBits-2:0], recBackup.predTaken};
        if (recovery.histAct == HIST_APPEND_1)
            recHistory = {recHistory[histBits-2:0], 1'b1};
    end

    always_comb begin
        train = bpUpdate;
        train.valid = bpUpdate.valid && bpUpdate.bpi.predicted && bpUpdate.bpi.kind == BR_COND;
    end

    always_ff @(posedge clk) begin
        if (mispr) begin
            recovery.fetchID <= misprFetchID;
            recovery.fetchOffs <= misprOffs;
            recovery.histAct <= misprHistAct;
        end
        tageWrite <= train;
        tageWriteHistory <= updBackup.history; // history in use when the branch was predicted.
        if (rst) begin
            recovery.valid <= 1'b0;
            tageWrite.valid <= 1'b0;
            history <= '0;
        end else begin
            recovery.valid <= mispr;
            if (recovery.valid)
                history <= recHistory;
            else if (pcValid && predBr.valid && predBr.kind == BR_COND)
                history <= {history[histBits-2:0], branchTaken};
        end
    end

endmodule

// File: branchPredictor/returnStack.sv
`timescale 1ns/10ps

module returnStack (
    input  logic clk,
    input  logic rst,
    input  logic pcValid,
    input  branchPkg::FetchAddr_t pc,
    input  logic brValid,
    input  branchPkg::FetchOff_t brOffs,
    input  branchPkg::BranchKind brKind,
    input  logic setIdx,
    input  branchPkg::RetStackIdx_t idx,
    output branchPkg::RetStackIdx_t curIdx,
    output branchPkg::PredBranch retBr
);
    import branchPkg::*;

    localparam int depth = 1 << $bits(RetStackIdx_t);

    FetchAddr_t stack[depth];
    FetchAddr_t retAddr;
    logic push;
    logic pop;

    // the return lands on the halfword after the call.
    assign retAddr = {pc[$bits(FetchAddr_t)-1:3], brOffs} + 1'b1;
    assign push = pcValid && brValid && brKind == BR_CALL;
    assign pop = pcValid && brValid && brKind == BR_RET;

    always_comb begin
        retBr.valid = brValid && brKind == BR_RET;
        retBr.offs = brOffs;
        retBr.dst = stack[curIdx];
        retBr.kind = BR_RET;
    end

    always_ff @(posedge clk) begin
        if (rst)
            curIdx <= '0;
        else if (setIdx)
            curIdx <= idx; // recovery overrides this cycle's push or pop.
        else if (push)
            curIdx <= curIdx + 1'b1;
        else if (pop)
            curIdx <= curIdx - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (push)
            stack[curIdx + 1'b1] <= retAddr; // oldest entry is overwritten when full.
    end

endmodule

// File: branchPredictor/tagePredictor.sv
`timescale 1ns/10ps

module tagePredictor #(
    parameter TAGE_ENTRIES = 32
) (
    input  logic clk,
    input  logic rst,
    input  branchPkg::FetchAddr_t predAddr,
    input  branchPkg::BHist_t predHistory,
    input  logic writeValid,
    input  branchPkg::FetchAddr_t writeAddr,
    input  branchPkg::BHist_t writeHistory,
    input  branchPkg::TageID_t writeTageID,
    input  logic writeTaken,
    input  logic writeAltPred,
    input  logic writePred,
    output logic predTaken,
    output branchPkg::TageID_t predTageID,
    output logic altPred
);
    import branchPkg::*;

    localparam int idxBits = $clog2(TAGE_ENTRIES);
    localparam int tagBits = 4;

    logic [1:0] baseCtr[TAGE_ENTRIES];
    logic [1:0] tagCtr[TAGE_ENTRIES];
    logic [tagBits-1:0] tagTag[TAGE_ENTRIES];
    logic [TAGE_ENTRIES-1:0] tagValid;

    logic [idxBits-1:0] predBase;
    logic [idxBits-1:0] predIdx;
    logic [tagBits-1:0] predTag;
    logic [idxBits-1:0] writeBase;
    logic [idxBits-1:0] writeIdx;
    logic [tagBits-1:0] writeTag;
    logic tagHit;

    function automatic logic [idxBits-1:0] hashIdx(FetchAddr_t a, BHist_t h);
        return a[3 +: idxBits] ^ idxBits'(h);
    endfunction

    function automatic logic [tagBits-1:0] hashTag(FetchAddr_t a, BHist_t h);
        return a[3 + idxBits +: tagBits] ^ h[$bits(BHist_t)-1 -: tagBits];
    endfunction

    function automatic logic [1:0] bump(logic [1:0] c, logic up);
        if (up)
            return (c == 2'b11) ? c : c + 2'b01;
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

    assign predBase = predAddr[3 +: idxBits];
    assign predIdx = hashIdx(predAddr, predHistory);
    assign predTag = hashTag(predAddr, predHistory);
    assign writeBase = writeAddr[3 +: idxBits];
    assign writeIdx = hashIdx(writeAddr, writeHistory);
    assign writeTag = hashTag(writeAddr, writeHistory);

    assign tagHit = tagValid[predIdx] && tagTag[predIdx] == predTag;
    assign altPred = baseCtr[predBase][1];
    assign predTageID = tagHit;
    assign predTaken = tagHit ? tagCtr[predIdx][1] : altPred;

    always_ff @(posedge clk) begin
        if (rst) begin
            tagValid <= '0;
            for (int i = 0; i < TAGE_ENTRIES; i++)
                baseCtr[i] <= 2'b01;
        end else if (writeValid) begin
            // the base also learns when it would have been the better guess.
            if (!writeTageID || writeAltPred != writeTaken)
                baseCtr[writeBase] <= bump(baseCtr[writeBase], writeTaken);
            if (!writeTageID && writePred != writeTaken)
                tagValid[writeIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (writeValid) begin
            if (writeTageID) begin
                tagCtr[writeIdx] <= bump(tagCtr[writeIdx], writeTaken);
            end else if (writePred != writeTaken) begin
                tagTag[writeIdx] <= writeTag;
                tagCtr[writeIdx] <= writeTaken ? 2'b10 : 2'b01; // allocated weak.
            end
        end
    end

endmodule

// File: common/branchPkg.sv
package branchPkg;

    typedef logic [30:0] FetchAddr_t; // halfword address.
    typedef logic [2:0] FetchOff_t;   // halfword slot within an 8-halfword block.
    typedef logic [3:0] FetchID_t;
    typedef logic [7:0] BHist_t;
    typedef logic [1:0] RetStackIdx_t;
    typedef logic TageID_t;           // 0 is the base table, 1 the tagged table.

    typedef enum logic [1:0] {
        BR_COND,
        BR_JUMP,
        BR_CALL,
        BR_RET
    } BranchKind;

    typedef enum logic [1:0] {
        HIST_NONE,
        HIST_WRITE_0,
        HIST_WRITE_1,
        HIST_APPEND_1
    } HistoryAction;

    typedef struct packed {
        logic valid;
        FetchOff_t offs;
        FetchAddr_t dst;
        BranchKind kind;
    } PredBranch;

    typedef struct packed {
        logic predicted;
        logic taken;
        BranchKind kind;
        TageID_t tageID;
        logic altPred;
        RetStackIdx_t rIdx;
    } BranchPredInfo;

    typedef struct packed {
        logic valid;
        FetchAddr_t pc;
        FetchOff_t offs;
        FetchAddr_t dst;
        BranchKind kind;
    } BTUpdate;

    typedef struct packed {
        logic valid;
        FetchID_t fetchID;
        FetchAddr_t pc;
        BranchPredInfo bpi;
        logic branchTaken;
    } BPUpdate;

    // state saved per fetch so that a misprediction can rewind it.
    typedef struct packed {
        BHist_t history;
        RetStackIdx_t rIdx;
        logic pred;
        logic predTaken;
        FetchOff_t predOffs;
    } BPBackup;

    typedef struct packed {
        logic valid;
        FetchID_t fetchID;
        FetchOff_t fetchOffs;
        HistoryAction histAct;
    } Recovery;

endpackage

// File: sim/predictorMonitor.sv
`timescale 1ns/10ps

module predictorMonitor (
    input  logic clk,
    input  logic rst,
    input  logic checkEn,
    input  branchPkg::PredBranch expBr,
    input  logic expTaken,
    input  logic expStall,
    input  branchPkg::PredBranch predBr,
    input  logic branchTaken,
    input  branchPkg::BranchPredInfo branchInfo,
    input  logic stall,
    output int errors,
    output int checks
);
    import branchPkg::*;

    int errorCount = 0;
    int checkCount = 0;

    assign errors = errorCount;
    assign checks = checkCount;

    task automatic compareField(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    // outputs are sampled at the edge, before it updates any state.
    always @(posedge clk) begin
        if (!rst && checkEn) begin
            checkCount++;
            compareField("predBr.valid", 32'(predBr.valid), 32'(expBr.valid));
            compareField("branchTaken", 32'(branchTaken), 32'(expTaken));
            compareField("stall", 32'(stall), 32'(expStall));
            compareField("branchInfo.predicted", 32'(branchInfo.predicted), 32'(expBr.valid));
            compareField("branchInfo.taken", 32'(branchInfo.taken), 32'(expTaken));
            if (expBr.valid) begin // the other fields only mean something for a valid branch.
                compareField("predBr.offs", 32'(predBr.offs), 32'(expBr.offs));
                compareField("predBr.dst", 32'(predBr.dst), 32'(expBr.dst));
                compareField("predBr.kind", 32'(predBr.kind), 32'(expBr.kind));
                compareField("branchInfo.kind", 32'(branchInfo.kind), 32'(expBr.kind));
            end
        end
    end

endmodule

// File: sim/predictorTb.sv
`timescale 1ns/10ps

module predictorTb;
    import branchPkg::*;

    typedef enum logic [2:0] {
        ROW_IDLE,
        ROW_FETCH,
        ROW_BTB,
        ROW_COMMIT,
        ROW_MISPR
    } RowKind;

    // one row is one clock cycle of stimulus and the outputs expected during it.
    typedef struct packed {
        RowKind op;
        FetchAddr_t pc;
        FetchID_t id;
        FetchOff_t offs;
        FetchAddr_t dst;
        BranchKind kind;
        logic both;           // the buffer update also drives a decoy on port 0.
        BranchPredInfo bpi;
        logic outcome;
        HistoryAction histAct;
        PredBranch expBr;
        logic expTaken;
        logic expStall;
    } Row;

    localparam FetchAddr_t blkEmpty = 31'h100;   // same buffer index as blkJump, other tag.
    localparam FetchAddr_t blkJump = 31'h200;
    localparam FetchAddr_t blkCond = 31'h310;
    localparam FetchAddr_t blkCallA = 31'h420;
    localparam FetchAddr_t blkRet = 31'h530;
    localparam FetchAddr_t blkCallB = 31'h640;
    localparam FetchAddr_t blkPair = 31'h750;
    localparam FetchAddr_t retA = blkCallA + 31'd2 + 31'd1; // block plus offset plus one.
    localparam FetchAddr_t retB = blkCallB + 31'd6 + 31'd1;
    localparam FetchAddr_t decoyDst = 31'h7000;
    localparam PredBranch noBranch = '0;

    logic clk;
    logic rst;
    logic pcValid;
    FetchAddr_t pc;
    FetchID_t fetchID;
    PredBranch predBr;
    logic branchTaken;
    BranchPredInfo branchInfo;
    logic stall;
    logic mispr;
    FetchID_t misprFetchID;
    FetchOff_t misprOffs;
    HistoryAction misprHistAct;
    BTUpdate btUpdates[2];
    BPUpdate bpUpdate;

    logic checkEn;
    PredBranch expBr;
    logic expTaken;
    logic expStall;
    int errors;
    int checks;
    int cycles = 0;
    Row rows[$];

    fetchPredictTop #(.NUM_IN(2), .BTB_ENTRIES(16), .TAGE_ENTRIES(32)) uut (
        .clk(clk), .rst(rst), .pcValid(pcValid), .pc(pc), .fetchID(fetchID),
        .predBr(predBr), .branchTaken(branchTaken), .branchInfo(branchInfo),
        .stall(stall), .mispr(mispr), .misprFetchID(misprFetchID),
        .misprOffs(misprOffs), .misprHistAct(misprHistAct),
        .btUpdates(btUpdates), .bpUpdate(bpUpdate)
    );

    predictorMonitor monitor (
        .clk(clk), .rst(rst), .checkEn(checkEn), .expBr(expBr), .expTaken(expTaken),
        .expStall(expStall), .predBr(predBr), .branchTaken(branchTaken),
        .branchInfo(branchInfo), .stall(stall), .errors(errors), .checks(checks)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic PredBranch branchAt(FetchOff_t offs, FetchAddr_t dst, BranchKind kind);
        return '{valid: 1'b1, offs: offs, dst: dst, kind: kind};
    endfunction

    task automatic fetchRow(FetchAddr_t addr, FetchID_t id, PredBranch exp, logic taken);
        Row r;
        r = '0;
        r.op = ROW_FETCH;
        r.pc = addr;
        r.id = id;
        r.expBr = exp;
        r.expTaken = taken;
        rows.push_back(r);
    endtask

    task automatic btbRow(FetchAddr_t addr, FetchOff_t offs, FetchAddr_t dst, BranchKind kind,
                          logic both);
        Row r;
        r = '0;
        r.op = ROW_BTB;
        r.pc = addr;
        r.offs = offs;
        r.dst = dst;
        r.kind = kind;
        r.both = both;
        rows.push_back(r);
    endtask

    task automatic commitRow(FetchAddr_t addr, FetchID_t id, logic predTaken, TageID_t provider,
                             logic alt, logic outcome);
        Row r;
        r = '0;
        r.op = ROW_COMMIT;
        r.pc = addr;
        r.id = id;
        r.bpi = '{predicted: 1'b1, taken: predTaken, kind: BR_COND, tageID: provider,
                  altPred: alt, rIdx: '0};
        r.outcome = outcome;
        rows.push_back(r);
    endtask

    task automatic misprRow(FetchID_t id, FetchOff_t offs, HistoryAction act);
        Row r;
        r = '0;
        r.op = ROW_MISPR;
        r.id = id;
        r.offs = offs;
        r.histAct = act;
        rows.push_back(r);
    endtask

    task automatic idleRow(logic stallHigh);
        Row r;
        r = '0;
        r.expStall = stallHigh;
        rows.push_back(r);
    endtask

    task automatic applyRow(Row r);
        pcValid = r.op == ROW_FETCH;
        pc = r.pc;
        fetchID = r.id;
        mispr = r.op == ROW_MISPR;
        misprFetchID = r.id;
        misprOffs = r.offs;
        misprHistAct = r.histAct;
        btUpdates[0] = '0;
        btUpdates[1] = '0;
        if (r.op == ROW_BTB && r.both) begin
            btUpdates[0] = '{valid: 1'b1, pc: r.pc, offs: 3'd0, dst: decoyDst, kind: BR_JUMP};
            btUpdates[1] = '{valid: 1'b1, pc: r.pc, offs: r.offs, dst: r.dst, kind: r.kind};
        end else if (r.op == ROW_BTB) begin
            btUpdates[0] = '{valid: 1'b1, pc: r.pc, offs: r.offs, dst: r.dst, kind: r.kind};
        end
        bpUpdate = '0;
        if (r.op == ROW_COMMIT)
            bpUpdate = '{valid: 1'b1, fetchID: r.id, pc: r.pc, bpi: r.bpi,
                         branchTaken: r.outcome};
        expBr = r.expBr;
        expTaken = r.expTaken;
        expStall = r.expStall;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > rows.size() * 4 + 64) begin
            $display("timeout after %0d cycles, the table never finished", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        Row blank;
        int assertFails;
        blank = '0;
        rst = 1'b1;
        checkEn = 1'b0;
        applyRow(blank);

        // an empty predictor predicts nothing.
        fetchRow(blkEmpty, 4'd0, noBranch, 1'b0);
        fetchRow(blkJump, 4'd1, noBranch, 1'b0);
        // a jump is seen from the next cycle, but not from past its offset.
        btbRow(blkJump, 3'd3, 31'h1000, BR_JUMP, 1'b0);
        fetchRow(blkJump, 4'd2, branchAt(3'd3, 31'h1000, BR_JUMP), 1'b1);
        fetchRow(blkJump + 31'd3, 4'd3, branchAt(3'd3, 31'h1000, BR_JUMP), 1'b1);
        fetchRow(blkJump + 31'd4, 4'd4, noBranch, 1'b0);
        fetchRow(blkEmpty, 4'd5, noBranch, 1'b0);
        // conditional branch trained taken once, then not taken twice.
        btbRow(blkCond, 3'd5, 31'h2000, BR_COND, 1'b0);
        fetchRow(blkCond, 4'd6, branchAt(3'd5, 31'h2000, BR_COND), 1'b0);
        commitRow(blkCond, 4'd6, 1'b0, 1'b0, 1'b0, 1'b1);
        idleRow(1'b0);
        fetchRow(blkCond, 4'd7, branchAt(3'd5, 31'h2000, BR_COND), 1'b1);
        commitRow(blkCond, 4'd7, 1'b1, 1'b1, 1'b1, 1'b0);
        commitRow(blkCond, 4'd7, 1'b1, 1'b1, 1'b1, 1'b0);
        misprRow(4'd7, 3'd5, HIST_WRITE_0); // puts the history back to zero.
        idleRow(1'b1);
        fetchRow(blkCond, 4'd8, branchAt(3'd5, 31'h2000, BR_COND), 1'b0);
        // calls and returns in last-in, first-out order.
        btbRow(blkCallA, 3'd2, 31'h3000, BR_CALL, 1'b0);
        btbRow(blkRet, 3'd4, 31'h0, BR_RET, 1'b0);
        btbRow(blkCallB, 3'd6, 31'h3800, BR_CALL, 1'b0);
        fetchRow(blkCallA, 4'd9, branchAt(3'd2, 31'h3000, BR_CALL), 1'b1);
        fetchRow(blkRet, 4'd10, branchAt(3'd4, retA, BR_RET), 1'b1);
        fetchRow(blkCallA, 4'd11, branchAt(3'd2, 31'h3000, BR_CALL), 1'b1);
        fetchRow(blkCallB, 4'd12, branchAt(3'd6, 31'h3800, BR_CALL), 1'b1);
        fetchRow(blkRet, 4'd13, branchAt(3'd4, retB, BR_RET), 1'b1);
        fetchRow(blkRet, 4'd14, branchAt(3'd4, retA, BR_RET), 1'b1);
        // recovery to a fetch saved before the second call.
        fetchRow(blkCallA, 4'd15, branchAt(3'd2, 31'h3000, BR_CALL), 1'b1);
        fetchRow(blkEmpty, 4'd0, noBranch, 1'b0);
        fetchRow(blkCallB, 4'd1, branchAt(3'd6, 31'h3800, BR_CALL), 1'b1);
        misprRow(4'd0, 3'd0, HIST_NONE);
        idleRow(1'b1);
        fetchRow(blkRet, 4'd2, branchAt(3'd4, retA, BR_RET), 1'b1);
        // port 1 beats port 0 in the same cycle.
        btbRow(blkPair, 3'd5, 31'h5000, BR_JUMP, 1'b1);
        fetchRow(blkPair, 4'd3, branchAt(3'd5, 31'h5000, BR_JUMP), 1'b1);

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkEn = 1'b1;
        foreach (rows[i]) begin
            applyRow(rows[i]);
            @(negedge clk);
        end
        checkEn = 1'b0;
        applyRow(blank);

        assertFails = uut.control.controlChecks.failCount;
        if (checks != rows.size())
            $display("only %0d of %0d table rows were compared", checks, rows.size());
        $display("rows compared: %0d, mismatches: %0d, assertion failures: %0d",
                 checks, errors, assertFails);
        if (errors == 0 && assertFails == 0 && checks == rows.size())
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: sim/predictor_checker.sv
`timescale 1ns/10ps

module predictorChecker (
    input  logic clk,
    input  logic rst,
    input  logic mispr,
    input  logic stall,
    input  logic pcValid,
    input  logic writeEnable,
    input  branchPkg::FetchAddr_t pc,
    input  branchPkg::PredBranch predBr
);
    int failCount = 0;

    // stall is high in exactly the cycle after each misprediction.
    stallFollowsMispr: assert property (@(posedge clk) disable iff (rst) mispr |=> stall)
        else begin
            $error("stall did not rise in the cycle after a misprediction");
            failCount++;
        end

    stallNeedsMispr: assert property (@(posedge clk) disable iff (rst) stall |-> $past(mispr))
        else begin
            $error("stall is high without a misprediction in the cycle before");
            failCount++;
        end

    backupOnFetch: assert property (@(posedge clk) disable iff (rst) writeEnable == pcValid)
        else begin
            $error("backup write enable differs from the fetch valid");
            failCount++;
        end

    noPassedBranch: assert property (@(posedge clk) disable iff (rst)
        predBr.valid |-> predBr.offs >= pc[2:0])
        else begin
            $error("a branch before the fetch offset was predicted");
            failCount++;
        end

endmodule

bind predictorControl predictorChecker controlChecks (
    .clk(clk), .rst(rst), .mispr(mispr), .stall(stall), .pcValid(pcValid),
    .writeEnable(writeEnable), .pc(pc), .predBr(predBr)
);

// File: source/backupFile.sv
`timescale 1ns/10ps

module backupFile (
    input  logic clk,
    input  logic writeEnable,
    input  branchPkg::FetchID_t writeID,
    input  branchPkg::BPBackup writeData,
    input  branchPkg::FetchID_t recAddr,
    input  branchPkg::FetchID_t updAddr,
    output branchPkg::BPBackup recData,
    output branchPkg::BPBackup updData
);
    import branchPkg::*;

    localparam int entries = 1 << $bits(FetchID_t);

    BPBackup backups[entries];

    // both reads are combinational.
    assign recData = backups[recAddr];
    assign updData = backups[updAddr];

    always_ff @(posedge clk) begin
        if (writeEnable)
            backups[writeID] <= writeData;
    end

endmodule

// File: source/fetchPredictTop.sv
`timescale 1ns/10ps

module fetchPredictTop #(
    parameter NUM_IN = 2,
    parameter BTB_ENTRIES = 16,
    parameter TAGE_ENTRIES = 32
) (
    input  logic clk,
    input  logic rst,
    input  logic pcValid,
    input  branchPkg::FetchAddr_t pc,
    input  branchPkg::FetchID_t fetchID,
    output branchPkg::PredBranch predBr,
    output logic branchTaken,
    output branchPkg::BranchPredInfo branchInfo,
    output logic stall,
    input  logic mispr,
    input  branchPkg::FetchID_t misprFetchID,
    input  branchPkg::FetchOff_t misprOffs,
    input  branchPkg::HistoryAction misprHistAct,
    input  branchPkg::BTUpdate btUpdates[NUM_IN],
    input  branchPkg::BPUpdate bpUpdate
);
    import branchPkg::*;

    PredBranch btbBr;
    PredBranch retBr;
    logic tageTaken;
    TageID_t tageID;
    logic altPred;
    RetStackIdx_t curIdx;
    RetStackIdx_t idx;
    logic setIdx;
    BPBackup recBackup;
    BPBackup updBackup;
    BPBackup writeData;
    logic writeEnable;
    FetchID_t writeID;
    FetchID_t recAddr;
    FetchID_t updAddr;
    BPUpdate tageWrite;
    BHist_t tageWriteHistory;
    BHist_t history;
    BTUpdate btUpdate;

    predictorControl #(.NUM_IN(NUM_IN)) control (
        .clk(clk), .rst(rst), .pcValid(pcValid), .pc(pc), .fetchID(fetchID),
        .btbBr(btbBr), .tageTaken(tageTaken), .tageID(tageID), .altPred(altPred),
        .retBr(retBr), .curIdx(curIdx), .recBackup(recBackup), .updBackup(updBackup),
        .mispr(mispr), .misprFetchID(misprFetchID), .misprOffs(misprOffs),
        .misprHistAct(misprHistAct), .btUpdates(btUpdates), .bpUpdate(bpUpdate),
        .predBr(predBr), .branchTaken(branchTaken), .branchInfo(branchInfo),
        .stall(stall), .history(history), .writeEnable(writeEnable),
        .writeID(writeID), .writeData(writeData), .recAddr(recAddr), .updAddr(updAddr),
        .tageWrite(tageWrite), .tageWriteHistory(tageWriteHistory),
        .setIdx(setIdx), .idx(idx), .btUpdate(btUpdate)
    );

    branchTargetBuffer #(.BTB_ENTRIES(BTB_ENTRIES)) btb (
        .clk(clk), .rst(rst), .pcValid(pcValid), .pc(pc),
        .btUpdate(btUpdate), .br(btbBr)
    );

    tagePredictor #(.TAGE_ENTRIES(TAGE_ENTRIES)) tage (
        .clk(clk), .rst(rst), .predAddr(pc), .predHistory(history),
        .writeValid(tageWrite.valid), .writeAddr(tageWrite.pc),
        .writeHistory(tageWriteHistory), .writeTageID(tageWrite.bpi.tageID),
        .writeTaken(tageWrite.branchTaken), .writeAltPred(tageWrite.bpi.altPred),
        .writePred(tageWrite.bpi.taken), .predTaken(tageTaken),
        .predTageID(tageID), .altPred(altPred)
    );

    returnStack retStack (
        .clk(clk), .rst(rst), .pcValid(pcValid), .pc(pc),
        .brValid(btbBr.valid), .brOffs(btbBr.offs), .brKind(btbBr.kind),
        .setIdx(setIdx), .idx(idx), .curIdx(curIdx), .retBr(retBr)
    );

    backupFile backups (
        .clk(clk), .writeEnable(writeEnable), .writeID(writeID), .writeData(writeData),
        .recAddr(recAddr), .updAddr(updAddr), .recData(recBackup), .updData(updBackup)
    );

endmodule
